// File: project.f
+incdir+source
source/ex_pkg.sv
source/alu.sv
source/branch_unit.sv
source/csr_buffer.sv
source/multiplier.sv
source/flu_writeback.sv
source/ex_stage.sv
bench/ex_stage_asserts.sv
bench/ex_stage_tb.sv

// File: Makefile
# Verilator flow for the execute stage testbench
TOP := ex_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// File: bench/ex_stage_tb.sv
// Testbench for the fixed-latency execute stage
// Inputs change 2 ns after the rising edge; concurrent checks sample on the edge
// Reference model follows the issue, branch, CSR and multiply rules of the stage
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_stage_tb;
    import ex_pkg::*;

    localparam int          CLK_PERIOD      = 20;
    localparam int          NUM_ALU         = 40;
    localparam int          NUM_BRANCH      = 60;
    localparam int          NUM_MULT        = 20;
    localparam int          WATCHDOG_CYCLES = 2 * (NUM_ALU + NUM_BRANCH + NUM_MULT) + 160;
    localparam int unsigned SEED            = 32'h1dd8_2c20;

    logic      clk_i, rst_ni, flush, csr_commit;
    fu_op_t    fu_op;
    xlen_t     operand_a, operand_b, imm, pc, predict_target;
    trans_id_t trans_id;
    logic      is_compressed, predict_taken;
    logic      alu_valid, branch_valid, csr_valid, mult_valid;

    xlen_t     flu_result, branch_target;
    trans_id_t flu_trans_id;
    logic      flu_valid, flu_ready, resolve_branch, branch_taken, mispredict;
    csr_addr_t csr_addr;

    // Reference model state and expectations
    logic      mult_pend_q, csr_full_q, mult_live;
    xlen_t     mult_res_q;
    trans_id_t mult_id_q, exp_trans_id;
    csr_addr_t csr_addr_q;
    xlen_t     exp_link, exp_target, exp_result;
    logic      exp_taken, exp_mispredict, exp_valid;
    int        error_count;

    ex_stage dut0 (
        .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush),
        .fu_op_i (fu_op), .operand_a_i (operand_a), .operand_b_i (operand_b),
        .imm_i (imm), .trans_id_i (trans_id), .pc_i (pc), .is_compressed_i (is_compressed),
        .alu_valid_i (alu_valid), .branch_valid_i (branch_valid),
        .csr_valid_i (csr_valid), .mult_valid_i (mult_valid),
        .predict_taken_i (predict_taken), .predict_target_i (predict_target),
        .csr_commit_i (csr_commit),
        .flu_result_o (flu_result), .flu_trans_id_o (flu_trans_id),
        .flu_valid_o (flu_valid), .flu_ready_o (flu_ready), .csr_addr_o (csr_addr),
        .resolve_branch_o (resolve_branch), .branch_taken_o (branch_taken),
        .branch_target_o (branch_target), .mispredict_o (mispredict)
    );

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic xlen_t alu_model(fu_op_t op, xlen_t a, xlen_t b);
        case (op)
            `EX_OP_ADD: return a + b;
            `EX_OP_SUB: return a + ~b + 32'd1;
            `EX_OP_AND: return a & b;
            `EX_OP_OR:  return a | b;
            `EX_OP_XOR: return a ^ b;
            `EX_OP_SLL: return a << b[4:0];
            `EX_OP_SRL: return a >> b[4:0];
            default:    return '0;
        endcase
    endfunction

    // Signed less-than from the sign bits, unsigned compare when they match
    function automatic logic cmp_model(fu_op_t op, xlen_t a, xlen_t b);
        logic lt;
        lt = (a[31] != b[31]) ? a[31] : (a < b);
        case (op)
            `EX_OP_EQ: return a == b;
            `EX_OP_NE: return a != b;
            `EX_OP_LT: return lt;
            `EX_OP_GE: return !lt;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic xlen_t mult_model(xlen_t a, xlen_t b);
        logic [63:0] full;
        full = {32'd0, a} * {32'd0, b};
        return full[31:0];
    endfunction

    always_comb begin
        exp_link       = pc + (is_compressed ? 32'd2 : 32'd4);
        exp_taken      = cmp_model(fu_op, operand_a, operand_b);
        exp_target     = exp_taken ? pc + imm : exp_link;
        exp_mispredict = (exp_taken != predict_taken) ||
                         (exp_taken && predict_taken && exp_target != predict_target);
        mult_live      = mult_pend_q && !flush;
        exp_valid      = alu_valid || branch_valid || csr_valid || mult_live;
        exp_trans_id   = trans_id;
        exp_result     = '0;
        if (alu_valid) begin
            exp_result = alu_model(fu_op, operand_a, operand_b);
        end else if (branch_valid) begin
            exp_result = exp_link;
        end else if (csr_valid) begin
            exp_result = operand_a;
        end else if (mult_live) begin
            exp_result   = mult_res_q;
            exp_trans_id = mult_id_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mult_pend_q <= 1'b0;
            csr_full_q  <= 1'b0;
        end else begin
            mult_pend_q <= mult_valid && !flush;
            if (mult_valid) begin
                mult_res_q <= mult_model(operand_a, operand_b);
                mult_id_q  <= trans_id;
            end
            if (flush || csr_commit) begin
                csr_full_q <= 1'b0;
            end else if (csr_valid) begin
                csr_full_q <= 1'b1;
                csr_addr_q <= operand_b[11:0];
            end
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        error_count = error_count + 1;
        $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
    endtask

    valid_check: assert property (@(posedge clk_i) disable iff (!rst_ni) flu_valid == exp_valid)
        else report_mismatch("flu_valid_o", 32'($sampled(exp_valid)), 32'($sampled(flu_valid)));
    result_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exp_valid |-> flu_result == exp_result)
        else report_mismatch("flu_result_o", $sampled(exp_result), $sampled(flu_result));
    id_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exp_valid |-> flu_trans_id == exp_trans_id)
        else report_mismatch("flu_trans_id_o", 32'($sampled(exp_trans_id)),
                             32'($sampled(flu_trans_id)));
    resolve_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resolve_branch == branch_valid)
        else report_mismatch("resolve_branch_o", 32'($sampled(branch_valid)),
                             32'($sampled(resolve_branch)));
    taken_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        branch_valid |-> branch_taken == exp_taken)
        else report_mismatch("branch_taken_o", 32'($sampled(exp_taken)),
                             32'($sampled(branch_taken)));
    target_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        branch_valid |-> branch_target == exp_target)
        else report_mismatch("branch_target_o", $sampled(exp_target), $sampled(branch_target));
    mispredict_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        branch_valid |-> mispredict == exp_mispredict)
        else report_mismatch("mispredict_o", 32'($sampled(exp_mispredict)),
                             32'($sampled(mispredict)));
    ready_check: assert property (@(posedge clk_i) disable iff (!rst_ni) flu_ready == !csr_full_q)
        else report_mismatch("flu_ready_o", 32'(!$sampled(csr_full_q)), 32'($sampled(flu_ready)));
    addr_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_full_q |-> csr_addr == csr_addr_q)
        else report_mismatch("csr_addr_o", 32'($sampled(csr_addr_q)), 32'($sampled(csr_addr)));

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    // Advance one cycle and drop all strobes
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
        alu_valid    = 1'b0;
        branch_valid = 1'b0;
        csr_valid    = 1'b0;
        mult_valid   = 1'b0;
        csr_commit   = 1'b0;
        flush        = 1'b0;
    endtask

    task automatic wait_ready();
        while (!flu_ready) begin
            next_cycle();
        end
    endtask

    task automatic random_operands();
        operand_a = $urandom;
        operand_b = $urandom;
        trans_id  = trans_id_t'($urandom);
    endtask

    task automatic issue_mult();
        random_operands();
        fu_op      = `EX_OP_MUL;
        mult_valid = 1'b1;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        error_count = 0;
        rst_ni = 1'b0;
        {flush, csr_commit, alu_valid, branch_valid, csr_valid, mult_valid} = '0;
        {is_compressed, predict_taken} = '0;
        fu_op = `EX_OP_ADD;
        {operand_a, operand_b, imm, pc, predict_target} = '0;
        trans_id = '0;
        repeat (5) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        // Idle after reset, ready high and nothing valid
        repeat (3) next_cycle();

        repeat (NUM_ALU) begin
            next_cycle();
            random_operands();
            fu_op     = fu_op_t'(`EX_OP_ADD + $urandom_range(6, 0));
            alu_valid = 1'b1;
        end

        repeat (NUM_BRANCH) begin
            next_cycle();
            random_operands();
            if ($urandom_range(1, 0) == 0) begin
                operand_b = operand_a;
            end
            fu_op          = fu_op_t'(`EX_OP_EQ + $urandom_range(3, 0));
            pc             = $urandom & 32'hffff_fffe;
            imm            = $urandom;
            is_compressed  = 1'($urandom);
            predict_taken  = 1'($urandom);
            predict_target = ($urandom_range(1, 0) == 0) ? pc + imm : $urandom;
            branch_valid   = 1'b1;
        end

        // CSR issue released by commit, then by flush
        next_cycle();
        wait_ready();
        random_operands();
        fu_op     = `EX_OP_CSR;
        csr_valid = 1'b1;
        repeat (4) next_cycle();
        csr_commit = 1'b1;
        next_cycle();
        wait_ready();
        random_operands();
        csr_valid = 1'b1;
        repeat (3) next_cycle();
        flush = 1'b1;
        next_cycle();
        wait_ready();

        repeat (NUM_MULT) begin
            next_cycle();
            issue_mult();
        end
        repeat (2) next_cycle();
        // Flush in the result cycle, then in the issue cycle
        issue_mult();
        next_cycle();
        flush = 1'b1;
        next_cycle();
        issue_mult();
        flush = 1'b1;
        repeat (3) next_cycle();

        $display("Run complete: %0d errors", error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/ex_stage_asserts.sv
// Issue protocol checks, bound into the execute stage top level
// Reads the CSR buffer state through the hierarchy of ex_stage
`timescale 1ns/1ps
`default_nettype none

module ex_stage_asserts (
    input wire logic               clk_i,
    input wire logic               rst_ni,
    input wire logic               flush_i,
    input wire logic               csr_commit_i,
    input wire logic               alu_valid_i,
    input wire logic               branch_valid_i,
    input wire logic               csr_valid_i,
    input wire logic               mult_valid_i,
    input wire logic               ready_i,
    input wire ex_pkg::csr_state_e csr_state_i
);
    import ex_pkg::*;

    logic any_fixed;

    // Units that write back in the issue cycle
    assign any_fixed = alu_valid_i | branch_valid_i | csr_valid_i;

    one_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i}))
        else $error("more than one issue valid in a cycle");

    no_collision: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i |=> !any_fixed)
        else $error("ALU, branch or CSR issue in the multiply result cycle");

    issue_when_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !ready_i |-> !(any_fixed | mult_valid_i))
        else $error("issue valid while flu_ready_o is low");

    // Commit or flush empties a full buffer and reopens the issue port
    ready_when_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (csr_state_i == CSR_FULL) && (csr_commit_i || flush_i)
        |=> (csr_state_i == CSR_EMPTY) && ready_i)
        else $error("flu_ready_o not high with the CSR buffer emptied");

endmodule

bind ex_stage ex_stage_asserts asserts0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .csr_commit_i   (csr_commit_i),
    .alu_valid_i    (alu_valid_i),
    .branch_valid_i (branch_valid_i),
    .csr_valid_i    (csr_valid_i),
    .mult_valid_i   (mult_valid_i),
    .ready_i        (flu_ready_o),
    .csr_state_i    (csr_buffer_i.state_q)
);

`default_nettype wire

// File: source/ex_stage.sv
// Fixed-latency execute stage: ALU, branch unit, CSR buffer, multiplier
// Issuer holds at most one valid per cycle and none while flu_ready_o is low
// No ALU, branch or CSR issue in the cycle after a multiply
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    // Issue port
    input  ex_pkg::fu_op_t    fu_op_i,
    input  ex_pkg::xlen_t     operand_a_i,
    input  ex_pkg::xlen_t     operand_b_i,
    input  ex_pkg::xlen_t     imm_i,
    input  ex_pkg::trans_id_t trans_id_i,
    input  ex_pkg::xlen_t     pc_i,
    input  logic              is_compressed_i,
    input  logic              alu_valid_i,
    input  logic              branch_valid_i,
    input  logic              csr_valid_i,
    input  logic              mult_valid_i,
    // Prediction and commit
    input  logic              predict_taken_i,
    input  ex_pkg::xlen_t     predict_target_i,
    input  logic              csr_commit_i,
    // Writeback port
    output ex_pkg::xlen_t     flu_result_o,
    output ex_pkg::trans_id_t flu_trans_id_o,
    output logic              flu_valid_o,
    output logic              flu_ready_o,
    output ex_pkg::csr_addr_t csr_addr_o,
    // Branch resolution
    output logic              resolve_branch_o,
    output logic              branch_taken_o,
    output ex_pkg::xlen_t     branch_target_o,
    output logic              mispredict_o
);
    import ex_pkg::*;

    xlen_t     alu_result;
    logic      cmp_result;
    xlen_t     link_result;
    xlen_t     csr_result;
    logic      csr_ready;
    xlen_t     mult_result;
    trans_id_t mult_trans_id;
    logic      mult_valid;

    // ------------------------------------------------------------------
    // Functional units
    // ------------------------------------------------------------------
    // ALU also serves the branch compare
    alu alu_i (
        .fu_op_i      (fu_op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .valid_i      (alu_valid_i | branch_valid_i),
        .result_o     (alu_result),
        .cmp_result_o (cmp_result)
    );

    branch_unit branch_unit_i (
        .branch_valid_i   (branch_valid_i),
        .pc_i             (pc_i),
        .imm_i            (imm_i),
        .is_compressed_i  (is_compressed_i),
        .cmp_result_i     (cmp_result),
        .predict_taken_i  (predict_taken_i),
        .predict_target_i (predict_target_i),
        .link_result_o    (link_result),
        .resolve_branch_o (resolve_branch_o),
        .branch_taken_o   (branch_taken_o),
        .branch_target_o  (branch_target_o),
        .mispredict_o     (mispredict_o)
    );

    csr_buffer csr_buffer_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .csr_commit_i (csr_commit_i),
        .csr_ready_o  (csr_ready),
        .csr_result_o (csr_result),
        .csr_addr_o   (csr_addr_o)
    );

    multiplier multiplier_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .mult_valid_i    (mult_valid_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .trans_id_i      (trans_id_i),
        .mult_valid_o    (mult_valid),
        .mult_result_o   (mult_result),
        .mult_trans_id_o (mult_trans_id)
    );

    // ------------------------------------------------------------------
    // Writeback
    // ------------------------------------------------------------------
    flu_writeback flu_writeback_i (
        .alu_valid_i     (alu_valid_i),
        .branch_valid_i  (branch_valid_i),
        .csr_valid_i     (csr_valid_i),
        .trans_id_i      (trans_id_i),
        .alu_result_i    (alu_result),
        .link_result_i   (link_result),
        .csr_result_i    (csr_result),
        .mult_result_i   (mult_result),
        .mult_valid_i    (mult_valid),
        .mult_trans_id_i (mult_trans_id),
        .flu_result_o    (flu_result_o),
        .flu_trans_id_o  (flu_trans_id_o),
        .flu_valid_o     (flu_valid_o)
    );

    // Multiplier never stalls, CSR buffer is the only back-pressure
    assign flu_ready_o = csr_ready;

endmodule

`default_nettype wire

// File: source/flu_writeback.sv
// Shared writeback port of the fixed-latency units
// Priority ALU, CSR, multiplier, with the branch link as default
`timescale 1ns/1ps
`default_nettype none

module flu_writeback (
    input  logic              alu_valid_i,
    input  logic              branch_valid_i,
    input  logic              csr_valid_i,
    input  ex_pkg::trans_id_t trans_id_i,
    input  ex_pkg::xlen_t     alu_result_i,
    input  ex_pkg::xlen_t     link_result_i,
    input  ex_pkg::xlen_t     csr_result_i,
    input  ex_pkg::xlen_t     mult_result_i,
    input  logic              mult_valid_i,
    input  ex_pkg::trans_id_t mult_trans_id_i,
    output ex_pkg::xlen_t     flu_result_o,
    output ex_pkg::trans_id_t flu_trans_id_o,
    output logic              flu_valid_o
);

    always_comb begin
        flu_result_o   = link_result_i;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result_i;
        end else if (mult_valid_i) begin
            // Multiply carries the id it was issued with
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end
    end

    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;

endmodule

`default_nettype wire

// File: source/multiplier.sv
// One-cycle multiplier, returns the low word of the unsigned product
// Never stalls; a flush in the issue or the result cycle drops the result
`timescale 1ns/1ps
`default_nettype none

module multiplier (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              mult_valid_i,
    input  ex_pkg::xlen_t     operand_a_i,
    input  ex_pkg::xlen_t     operand_b_i,
    input  ex_pkg::trans_id_t trans_id_i,
    output logic              mult_valid_o,
    output ex_pkg::xlen_t     mult_result_o,
    output ex_pkg::trans_id_t mult_trans_id_o
);
    import ex_pkg::*;

    xlen_t     op_a;
    xlen_t     op_b;
    xlen_t     product_lo;
    logic      valid_q;
    xlen_t     result_q;
    trans_id_t trans_id_q;

    // Input silencing
    assign op_a = mult_valid_i ? operand_a_i : '0;
    assign op_b = mult_valid_i ? operand_b_i : '0;

    // Upper half of the product is not needed
    assign product_lo = op_a * op_b;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            result_q   <= product_lo;
            trans_id_q <= trans_id_i;
        end
    end

    // Late flush kills the result in its own cycle
    assign mult_valid_o    = valid_q & ~flush_i;
    assign mult_result_o   = result_q;
    assign mult_trans_id_o = trans_id_q;

endmodule

`default_nettype wire

// File: source/csr_buffer.sv
// Single-entry CSR address buffer
// While full, ready is low and the issue port is blocked
// Address holds from the cycle after issue until commit or flush
`timescale 1ns/1ps
`default_nettype none

module csr_buffer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              csr_valid_i,
    input  ex_pkg::xlen_t     operand_a_i,
    input  ex_pkg::xlen_t     operand_b_i,
    input  logic              csr_commit_i,
    output logic              csr_ready_o,
    output ex_pkg::xlen_t     csr_result_o,
    output ex_pkg::csr_addr_t csr_addr_o
);
    import ex_pkg::*;

    csr_state_e state_q;
    csr_state_e state_d;
    csr_addr_t  addr_q;

    // Next state, flush always empties the buffer
    always_comb begin
        state_d = state_q;
        case (state_q)
            CSR_EMPTY: if (csr_valid_i) state_d = CSR_FULL;
            CSR_FULL:  if (csr_commit_i) state_d = CSR_EMPTY;
            default:   state_d = CSR_EMPTY;
        endcase
        if (flush_i) begin
            state_d = CSR_EMPTY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= CSR_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // Capture the address on issue
    always_ff @(posedge clk_i) begin
        if (csr_valid_i && state_q == CSR_EMPTY) begin
            addr_q <= operand_b_i[$bits(csr_addr_t)-1:0];
        end
    end

    assign csr_ready_o  = (state_q == CSR_EMPTY);
    assign csr_result_o = operand_a_i;
    assign csr_addr_o   = addr_q;

endmodule

`default_nettype wire

// File: source/branch_unit.sv
// Branch resolution, combinational in the issue cycle
// Taken flag comes from the ALU compare; targets are pc relative only
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic          branch_valid_i,
    input  ex_pkg::xlen_t pc_i,
    input  ex_pkg::xlen_t imm_i,
    input  logic          is_compressed_i,
    input  logic          cmp_result_i,
    input  logic          predict_taken_i,
    input  ex_pkg::xlen_t predict_target_i,
    output ex_pkg::xlen_t link_result_o,
    output logic          resolve_branch_o,
    output logic          branch_taken_o,
    output ex_pkg::xlen_t branch_target_o,
    output logic          mispredict_o
);
    import ex_pkg::*;

    xlen_t link_addr;
    xlen_t jump_addr;
    xlen_t target;
    logic  taken;
    logic  dir_wrong;
    logic  target_wrong;

    // Next sequential pc
    assign link_addr = pc_i + (is_compressed_i ? xlen_t'(2) : xlen_t'(4));
    assign jump_addr = pc_i + imm_i;

    assign taken  = branch_valid_i & cmp_result_i;
    assign target = taken ? jump_addr : link_addr;

    // Wrong direction, or right direction but wrong target
    assign dir_wrong    = (taken != predict_taken_i);
    assign target_wrong = taken & predict_taken_i & (target != predict_target_i);

    // ------------------------------------------------------------------
    // Outputs, only meaningful with a branch issued
    // ------------------------------------------------------------------
    assign resolve_branch_o = branch_valid_i;
    assign branch_taken_o   = taken;
    assign branch_target_o  = branch_valid_i ? target : '0;
    assign link_result_o    = branch_valid_i ? link_addr : '0;
    assign mispredict_o     = branch_valid_i & (dir_wrong | target_wrong);

endmodule

`default_nettype wire

// File: source/alu.sv
// Single-cycle ALU, purely combinational
// Shifts use the low five bits of operand b; compares drive only cmp_result_o
// Operands read as zero while valid_i is low
`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module alu (
    input  ex_pkg::fu_op_t fu_op_i,
    input  ex_pkg::xlen_t  operand_a_i,
    input  ex_pkg::xlen_t  operand_b_i,
    input  logic           valid_i,
    output ex_pkg::xlen_t  result_o,
    output logic           cmp_result_o
);
    import ex_pkg::*;

    xlen_t      op_a;
    xlen_t      op_b;
    logic [4:0] shamt;

    // Silence the datapath when no ALU or branch op is issued
    assign op_a  = valid_i ? operand_a_i : '0;
    assign op_b  = valid_i ? operand_b_i : '0;
    assign shamt = op_b[4:0];

    // ------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------
    always_comb begin
        result_o     = '0;
        cmp_result_o = 1'b0;
        case (fu_op_i)
            `EX_OP_ADD: result_o = op_a + op_b;
            `EX_OP_SUB: result_o = op_a - op_b;
            `EX_OP_AND: result_o = op_a & op_b;
            `EX_OP_OR:  result_o = op_a | op_b;
            `EX_OP_XOR: result_o = op_a ^ op_b;
            `EX_OP_SLL: result_o = op_a << shamt;
            `EX_OP_SRL: result_o = op_a >> shamt;
            // Branch compares
            `EX_OP_EQ:  cmp_result_o = (op_a == op_b);
            `EX_OP_NE:  cmp_result_o = (op_a != op_b);
            `EX_OP_LT:  cmp_result_o = ($signed(op_a) < $signed(op_b));
            `EX_OP_GE:  cmp_result_o = ($signed(op_a) >= $signed(op_b));
            // MUL and CSR belong to other units
            default: begin
                result_o     = '0;
                cmp_result_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/ex_pkg.sv
// Vector types and the CSR buffer state for the execute stage
// Widths come from ex_defs.svh
`default_nettype none

`include "ex_defs.svh"

package ex_pkg;

    // Data word or address
    typedef logic [`EX_XLEN-1:0] xlen_t;

    // Scoreboard entry id
    typedef logic [`EX_TRANS_ID_BITS-1:0] trans_id_t;

    typedef logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_t;

    typedef logic [`EX_OP_BITS-1:0] fu_op_t;

    // Single-entry CSR buffer occupancy
    typedef enum logic {
        CSR_EMPTY = 1'b0,
        CSR_FULL  = 1'b1
    } csr_state_e;

endpackage

`default_nettype wire

// File: source/ex_defs.svh
// Widths and operation codes of the fixed-latency execute stage
// All widths are fixed here; no module takes a parameter
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`define EX_XLEN          32
`define EX_TRANS_ID_BITS 3
`define EX_CSR_ADDR_BITS 12
`define EX_OP_BITS       4

// Operation codes shared by the units and the issuer
`define EX_OP_ADD 4'h0
`define EX_OP_SUB 4'h1
`define EX_OP_AND 4'h2
`define EX_OP_OR  4'h3
`define EX_OP_XOR 4'h4
`define EX_OP_SLL 4'h5
`define EX_OP_SRL 4'h6
`define EX_OP_EQ  4'h7
`define EX_OP_NE  4'h8
`define EX_OP_LT  4'h9
`define EX_OP_GE  4'ha
`define EX_OP_MUL 4'hb
`define EX_OP_CSR 4'hc

`endif
